// ==== common/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ########################################################################
// cache geometry
// ########################################################################

`define FETCH_NUM_LINES      32
`define FETCH_ADDR_BITS      16
`define FETCH_OFFSET_BITS    3
`define FETCH_WORD_BITS      64
`define FETCH_INDEX_BITS     $clog2(`FETCH_NUM_LINES)
`define FETCH_LINE_TAG_BITS  (`FETCH_ADDR_BITS - `FETCH_INDEX_BITS - `FETCH_OFFSET_BITS)

// ########################################################################
// memory bus and flow control
// ########################################################################

`define FETCH_MEM_TAGS       16 // tag 0 on the bus stands for no tag.
`define FETCH_BUS_TAG_BITS   $clog2(`FETCH_MEM_TAGS)
`define FETCH_IBUF_DEPTH     4
`define FETCH_DECODE_CREDITS 2

`endif

// ==== common/mem_bus_pkg.sv ====
`include "fetch_config.svh"

package mem_bus_pkg;

  // ########################################################################
  // tagged memory bus
  // ########################################################################

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2  // held back for a later store path.
  } bus_command_t;

  typedef struct packed {
    bus_command_t                command;
    logic [`FETCH_ADDR_BITS-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [`FETCH_BUS_TAG_BITS-1:0] accept_tag; // nonzero when the request is taken.
    logic [`FETCH_WORD_BITS-1:0]    data;
    logic [`FETCH_BUS_TAG_BITS-1:0] data_tag;   // names the request that data answers.
  } mem_resp_t;

  // ########################################################################
  // one outstanding load per bus tag
  // ########################################################################

  typedef struct packed {
    logic                            valid;
    logic [`FETCH_INDEX_BITS-1:0]    index;
    logic [`FETCH_LINE_TAG_BITS-1:0] line_tag;
  } miss_entry_t;

endpackage

// ==== common/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

  // ########################################################################
  // cache view of a fetch address
  // ########################################################################

  typedef struct packed {
    logic [`FETCH_LINE_TAG_BITS-1:0] tag;
    logic [`FETCH_INDEX_BITS-1:0]    index;
    logic [`FETCH_OFFSET_BITS-1:0]   offset;
  } icache_fields_t;

  typedef union packed {
    logic [`FETCH_ADDR_BITS-1:0] raw;
    icache_fields_t              fields;
  } icache_addr_u;

  // ########################################################################
  // cache line and fetch packet
  // ########################################################################

  typedef struct packed {
    logic                            valid;
    logic [`FETCH_LINE_TAG_BITS-1:0] tag;
    logic [`FETCH_WORD_BITS-1:0]     data;
  } icache_line_t;

  typedef struct packed {
    logic [`FETCH_ADDR_BITS-1:0] pc;
    logic [`FETCH_WORD_BITS-1:0] word; // both instructions, split later by decode.
  } fetch_packet_t;

endpackage

// ==== icache/icache.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module icache (
  input  logic                             clock,
  input  logic                             reset,
  input  fetch_pkg::icache_addr_u          i_fetch_addr,
  input  mem_bus_pkg::mem_resp_t           i_mem_resp,
  input  logic                             i_fill_valid,
  input  logic [`FETCH_INDEX_BITS-1:0]     i_fill_index,
  input  logic [`FETCH_LINE_TAG_BITS-1:0]  i_fill_tag,
  input  logic [`FETCH_WORD_BITS-1:0]      i_fill_data,
  output mem_bus_pkg::mem_req_t            o_mem_req,
  output logic                             o_alloc_valid,
  output logic [`FETCH_BUS_TAG_BITS-1:0]   o_alloc_tag,
  output logic [`FETCH_INDEX_BITS-1:0]     o_alloc_index,
  output logic [`FETCH_LINE_TAG_BITS-1:0]  o_alloc_line_tag,
  output logic                             o_hit,
  output logic [`FETCH_WORD_BITS-1:0]      o_data
);
  import fetch_pkg::*;
  import mem_bus_pkg::*;

  localparam logic [`FETCH_ADDR_BITS-1:0] line_step = 1 << `FETCH_OFFSET_BITS;

  icache_line_t                    lines [`FETCH_NUM_LINES];
  logic [`FETCH_NUM_LINES-1:0]     line_pending; // a load for this index is on the bus.
  logic [`FETCH_INDEX_BITS-1:0]    head;
  icache_addr_u                    tail;         // next line to request.
  icache_addr_u                    next_tail;
  icache_addr_u                    issued;
  logic [`FETCH_INDEX_BITS-1:0]    idx;
  logic [`FETCH_LINE_TAG_BITS-1:0] tag;
  logic [`FETCH_INDEX_BITS-1:0]    tail_ahead;
  logic                            tag_match;
  logic                            accepted;
  logic                            requested;
  logic                            miss;
  logic                            window_full;

  // ########################################################################
  // lookup
  // ########################################################################

  assign idx       = i_fetch_addr.fields.index;
  assign tag       = i_fetch_addr.fields.tag;
  assign tag_match = (lines[idx].tag == tag);
  assign o_hit     = lines[idx].valid && tag_match;
  assign o_data    = lines[idx].data;

  // ########################################################################
  // request issue and prefetch window
  // ########################################################################

  assign issued   = o_mem_req.addr;
  assign accepted = (o_mem_req.command == BUS_LOAD) && (i_mem_resp.accept_tag != '0);

  assign o_alloc_valid    = accepted;
  assign o_alloc_tag      = i_mem_resp.accept_tag;
  assign o_alloc_index    = issued.fields.index;
  assign o_alloc_line_tag = issued.fields.tag;

  // an invalid line that nobody has asked for counts as a miss too.
  assign requested = line_pending[idx] || (accepted && (issued.fields.index == idx));
  assign miss      = !tag_match || (!lines[idx].valid && !requested);

  always_comb begin
    next_tail = tail;
    if (miss) begin
      next_tail               = i_fetch_addr; // restart the window at the missing line.
      next_tail.fields.offset = '0;
    end else if (accepted) begin
      next_tail.raw = tail.raw + line_step;
    end
  end

  assign tail_ahead  = next_tail.fields.index + 1'b1;
  assign window_full = (tail_ahead == head); // stop one line short of wrapping.

  always_ff @(posedge clock) begin
    if (reset) begin
      head              <= '0;
      tail              <= '0;
      o_mem_req.command <= BUS_NONE;
    end else begin
      head              <= idx;
      tail              <= next_tail;
      o_mem_req.command <= window_full ? BUS_NONE : BUS_LOAD;
      o_mem_req.addr    <= next_tail.raw;
    end
  end

  // ########################################################################
  // line storage
  // ########################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `FETCH_NUM_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
      line_pending <= '0;
    end else begin
      if (miss) begin
        lines[idx].valid <= 1'b0;
        lines[idx].tag   <= tag; // claim the line so the next cycle waits on it.
      end
      if (i_fill_valid) begin
        lines[i_fill_index]        <= '{valid: 1'b1, tag: i_fill_tag, data: i_fill_data};
        line_pending[i_fill_index] <= 1'b0;
      end
      if (accepted) begin
        line_pending[issued.fields.index] <= 1'b1; // a newer load wins over a fill.
      end
    end
  end

  a_fill_in_range: assert property (@(posedge clock) disable iff (reset)
    i_fill_valid |-> (i_fill_index < `FETCH_NUM_LINES))
    else $error("icache fill index %0d is outside the line array.", i_fill_index);

  a_quiet_in_reset: assert property (@(posedge clock)
    reset |=> (o_mem_req.command == BUS_NONE))
    else $error("icache issued a memory request out of reset.");

endmodule

// ==== icache/miss_tracker.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module miss_tracker (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             i_alloc_valid,
  input  logic [`FETCH_BUS_TAG_BITS-1:0]   i_alloc_tag,
  input  logic [`FETCH_INDEX_BITS-1:0]     i_alloc_index,
  input  logic [`FETCH_LINE_TAG_BITS-1:0]  i_alloc_line_tag,
  input  mem_bus_pkg::mem_resp_t           i_mem_resp,
  output logic                             o_fill_valid,
  output logic [`FETCH_INDEX_BITS-1:0]     o_fill_index,
  output logic [`FETCH_LINE_TAG_BITS-1:0]  o_fill_tag,
  output logic [`FETCH_WORD_BITS-1:0]      o_fill_data
);
  import mem_bus_pkg::*;

  miss_entry_t                    entries [`FETCH_MEM_TAGS];
  miss_entry_t                    returning;
  logic [`FETCH_BUS_TAG_BITS-1:0] data_tag;

  assign data_tag  = i_mem_resp.data_tag;
  assign returning = entries[data_tag];

  // the fill goes to the cache in the cycle the word arrives.
  assign o_fill_valid = (data_tag != '0) && returning.valid;
  assign o_fill_index = returning.index;
  assign o_fill_tag   = returning.line_tag;
  assign o_fill_data  = i_mem_resp.data;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `FETCH_MEM_TAGS; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      if (o_fill_valid) begin
        entries[data_tag].valid <= 1'b0;
      end
      if (i_alloc_valid) begin
        // memory may hand out a tag again in the cycle its data returns.
        entries[i_alloc_tag] <= '{valid: 1'b1, index: i_alloc_index,
                                  line_tag: i_alloc_line_tag};
      end
    end
  end

  a_known_data_tag: assert property (@(posedge clock) disable iff (reset)
    (data_tag != '0) |-> returning.valid)
    else $error("data tag %0d returned with no load outstanding.", data_tag);

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_stage (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         i_redirect,
  input  logic [`FETCH_ADDR_BITS-1:0]  i_redirect_pc,
  input  logic                         i_hit,
  input  logic [`FETCH_WORD_BITS-1:0]  i_data,
  input  logic                         i_slot_credit,
  output fetch_pkg::icache_addr_u      o_fetch_addr,
  output logic                         o_push,
  output fetch_pkg::fetch_packet_t     o_push_packet
);

  localparam int                          credit_bits = $clog2(`FETCH_IBUF_DEPTH + 1);
  localparam logic [`FETCH_ADDR_BITS-1:0] line_step   = 1 << `FETCH_OFFSET_BITS;

  logic [`FETCH_ADDR_BITS-1:0] pc;
  logic [credit_bits-1:0]      credits; // free slots in the instruction buffer.

  assign o_fetch_addr  = pc;
  assign o_push        = i_hit && (credits != '0) && !i_redirect;
  assign o_push_packet = '{pc: pc, word: i_data};

  // ########################################################################
  // program counter
  // ########################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (i_redirect) begin
      pc <= {i_redirect_pc[`FETCH_ADDR_BITS-1:`FETCH_OFFSET_BITS],
             {`FETCH_OFFSET_BITS{1'b0}}}; // targets are word aligned.
    end else if (o_push) begin
      pc <= pc + line_step;
    end
  end

  // ########################################################################
  // slot credits
  // ########################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      credits <= credit_bits'(`FETCH_IBUF_DEPTH);
    end else begin
      case ({o_push, i_slot_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // a spend and a return cancel out.
      endcase
    end
  end

  a_credit_bound: assert property (@(posedge clock) disable iff (reset)
    credits <= `FETCH_IBUF_DEPTH)
    else $error("fetch holds %0d credits for a %0d slot buffer.", credits,
                `FETCH_IBUF_DEPTH);

endmodule

// ==== logic/inst_buffer.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module inst_buffer (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      i_push,
  input  fetch_pkg::fetch_packet_t  i_push_packet,
  input  logic                      i_decode_credit,
  output logic                      o_slot_credit,
  output logic                      o_decode_valid,
  output fetch_pkg::fetch_packet_t  o_decode_packet
);
  import fetch_pkg::*;

  localparam int ptr_bits   = $clog2(`FETCH_IBUF_DEPTH);
  localparam int count_bits = $clog2(`FETCH_IBUF_DEPTH + 1);
  localparam int dcred_bits = $clog2(`FETCH_DECODE_CREDITS + 1);

  fetch_packet_t          slots [`FETCH_IBUF_DEPTH];
  logic [ptr_bits-1:0]    wr_ptr;
  logic [ptr_bits-1:0]    rd_ptr;
  logic [count_bits-1:0]  count;
  logic [dcred_bits-1:0]  decode_credits;
  logic                   pop;

  assign pop             = (count != '0) && (decode_credits != '0);
  assign o_decode_valid  = pop;
  assign o_decode_packet = slots[rd_ptr];
  assign o_slot_credit   = pop; // each pop frees one slot for fetch.

  always_ff @(posedge clock) begin
    if (i_push) begin
      slots[wr_ptr] <= i_push_packet;
    end
  end

  // ########################################################################
  // pointers and counters
  // ########################################################################

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      decode_credits <= dcred_bits'(`FETCH_DECODE_CREDITS);
    end else begin
      wr_ptr <= wr_ptr + ptr_bits'(i_push); // wraps with a power of two depth.
      rd_ptr <= rd_ptr + ptr_bits'(pop);
      case ({i_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({pop, i_decode_credit})
        2'b10:   decode_credits <= decode_credits - 1'b1;
        2'b01:   decode_credits <= decode_credits + 1'b1;
        default: decode_credits <= decode_credits;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    i_push |-> (count < `FETCH_IBUF_DEPTH))
    else $error("instruction buffer pushed while full.");

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_top (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         i_redirect,
  input  logic [`FETCH_ADDR_BITS-1:0]  i_redirect_pc,
  input  mem_bus_pkg::mem_resp_t       i_mem_resp,
  input  logic                         i_decode_credit,
  output mem_bus_pkg::mem_req_t        o_mem_req,
  output logic                         o_decode_valid,
  output fetch_pkg::fetch_packet_t     o_decode_packet
);
  import fetch_pkg::*;

  icache_addr_u                    fetch_addr;
  fetch_packet_t                   push_packet;
  logic                            hit;
  logic [`FETCH_WORD_BITS-1:0]     hit_data;
  logic                            push;
  logic                            slot_credit;
  logic                            alloc_valid;
  logic [`FETCH_BUS_TAG_BITS-1:0]  alloc_tag;
  logic [`FETCH_INDEX_BITS-1:0]    alloc_index;
  logic [`FETCH_LINE_TAG_BITS-1:0] alloc_line_tag;
  logic                            fill_valid;
  logic [`FETCH_INDEX_BITS-1:0]    fill_index;
  logic [`FETCH_LINE_TAG_BITS-1:0] fill_tag;
  logic [`FETCH_WORD_BITS-1:0]     fill_data;

  fetch_stage u_fetch_stage (
    .clock, .reset, .i_redirect, .i_redirect_pc,
    .i_hit(hit), .i_data(hit_data), .i_slot_credit(slot_credit),
    .o_fetch_addr(fetch_addr), .o_push(push), .o_push_packet(push_packet)
  );

  icache u_icache (
    .clock, .reset, .i_fetch_addr(fetch_addr), .i_mem_resp,
    .i_fill_valid(fill_valid), .i_fill_index(fill_index),
    .i_fill_tag(fill_tag), .i_fill_data(fill_data), .o_mem_req,
    .o_alloc_valid(alloc_valid), .o_alloc_tag(alloc_tag),
    .o_alloc_index(alloc_index), .o_alloc_line_tag(alloc_line_tag),
    .o_hit(hit), .o_data(hit_data)
  );

  miss_tracker u_miss_tracker (
    .clock, .reset, .i_alloc_valid(alloc_valid), .i_alloc_tag(alloc_tag),
    .i_alloc_index(alloc_index), .i_alloc_line_tag(alloc_line_tag), .i_mem_resp,
    .o_fill_valid(fill_valid), .o_fill_index(fill_index),
    .o_fill_tag(fill_tag), .o_fill_data(fill_data)
  );

  inst_buffer u_inst_buffer (
    .clock, .reset, .i_push(push), .i_push_packet(push_packet), .i_decode_credit,
    .o_slot_credit(slot_credit), .o_decode_valid, .o_decode_packet
  );

endmodule

// ==== verification/mem_model.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module mem_model (
  input  logic                    clock,
  input  logic                    reset,
  input  mem_bus_pkg::mem_req_t   i_mem_req,
  output mem_bus_pkg::mem_resp_t  o_mem_resp
);
  import mem_bus_pkg::*;

  localparam int tag_bits = `FETCH_BUS_TAG_BITS;

  mem_resp_t                   resp = '0;
  logic [`FETCH_MEM_TAGS-1:0]  pending;
  logic [`FETCH_ADDR_BITS-1:0] pending_addr [`FETCH_MEM_TAGS];
  int                          pending_wait [`FETCH_MEM_TAGS];

  assign o_mem_resp = resp;

  function automatic logic [`FETCH_WORD_BITS-1:0] word_at(
    input logic [`FETCH_ADDR_BITS-1:0] addr
  );
    return {addr, ~addr, addr, ~addr};
  endfunction

  always @(posedge clock) begin
    int start;
    int tag;
    if (reset) begin
      pending = '0;
    end else begin
      if (resp.data_tag != '0) begin
        pending[resp.data_tag] = 1'b0; // the tag is free once its data was seen.
      end
      for (int t = 1; t < `FETCH_MEM_TAGS; t++) begin
        if (pending[t]) begin
          pending_wait[t]--;
        end
      end
      if (i_mem_req.command == BUS_LOAD && resp.accept_tag != '0) begin
        pending[resp.accept_tag]      = 1'b1;
        pending_addr[resp.accept_tag] = i_mem_req.addr;
        pending_wait[resp.accept_tag] = $urandom_range(10, 3);
      end
    end
    #2;
    resp = '0;
    // ######################################################################
    // one return per cycle, then a grant offer for the next request
    // ######################################################################
    for (int t = 1; t < `FETCH_MEM_TAGS; t++) begin
      if (pending[t] && pending_wait[t] <= 0 && resp.data_tag == '0) begin
        resp.data_tag = tag_bits'(t);
        resp.data     = word_at(pending_addr[t]);
      end
    end
    if (!reset && $urandom_range(7, 0) != 0) begin
      start = $urandom_range(`FETCH_MEM_TAGS - 2, 0);
      for (int i = 0; i < `FETCH_MEM_TAGS - 1; i++) begin
        tag = 1 + (start + i) % (`FETCH_MEM_TAGS - 1);
        if (!pending[tag] && resp.accept_tag == '0) begin
          resp.accept_tag = tag_bits'(tag);
        end
      end
    end
  end

endmodule

// ==== verification/fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb;
  import fetch_pkg::*;
  import mem_bus_pkg::*;

  logic                        clock = 1'b0;
  logic                        reset;
  logic                        redirect;
  logic [`FETCH_ADDR_BITS-1:0] redirect_pc;
  logic                        decode_credit = 1'b0;
  mem_req_t                    mem_req;
  mem_resp_t                   mem_resp;
  logic                        decode_valid;
  fetch_packet_t               decode_packet;

  logic [`FETCH_MEM_TAGS-1:0]  granted;
  logic [`FETCH_ADDR_BITS-1:0] next_pc;
  logic [`FETCH_ADDR_BITS-1:0] redirect_target;
  logic                        redirect_pending;
  int                          decode_held;   // packets decode holds without a credit back.
  int                          decoded_count;
  int                          value_errors = 0;
  int                          protocol_errors = 0;
  int                          timeouts = 0;
  bit                          run_ok;

  fetch_top u_fetch_top (
    .clock, .reset, .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .i_mem_resp(mem_resp), .i_decode_credit(decode_credit),
    .o_mem_req(mem_req), .o_decode_valid(decode_valid), .o_decode_packet(decode_packet)
  );

  mem_model u_mem_model (.clock, .reset, .i_mem_req(mem_req), .o_mem_resp(mem_resp));

  always #20 clock = ~clock;

  function automatic logic [`FETCH_WORD_BITS-1:0] expected_word(
    input logic [`FETCH_ADDR_BITS-1:0] addr
  );
    return {addr, ~addr, addr, ~addr};
  endfunction

  // ########################################################################
  // reference state seen from the ports
  // ########################################################################

  always @(posedge clock) begin
    if (reset) begin
      granted          <= '0;
      next_pc          <= '0;
      redirect_pending <= 1'b0;
      decode_held      <= 0;
      decoded_count    <= 0;
    end else begin
      if (mem_resp.data_tag != '0) begin
        granted[mem_resp.data_tag] <= 1'b0;
      end
      if (mem_req.command == BUS_LOAD && mem_resp.accept_tag != '0) begin
        granted[mem_resp.accept_tag] <= 1'b1;
      end
      if (redirect) begin
        redirect_pending <= 1'b1;
        redirect_target  <= redirect_pc;
      end
      if (decode_valid) begin
        next_pc       <= decode_packet.pc + 16'd8;
        decoded_count <= decoded_count + 1;
        if (redirect_pending && decode_packet.pc == redirect_target) begin
          redirect_pending <= 1'b0;
        end
      end
      decode_held <= decode_held + int'(decode_valid) - int'(decode_credit);
    end
  end

  // decode hands a credit back for a held packet most cycles.
  always @(posedge clock) begin
    #2;
    if (reset) begin
      decode_credit = 1'b0;
    end else begin
      decode_credit = (decode_held > 0) && ($urandom_range(3, 0) != 0);
    end
  end

  // ########################################################################
  // checks
  // ########################################################################

  a_word_rule: assert property (@(posedge clock) disable iff (reset)
    decode_valid |-> (decode_packet.word == expected_word(decode_packet.pc)))
    else begin
      value_errors++;
      $display("FAILED at %0t: o_decode_packet.word = %h, expected %h", $time,
               $sampled(decode_packet.word), expected_word($sampled(decode_packet.pc)));
    end

  a_pc_order: assert property (@(posedge clock) disable iff (reset)
    decode_valid |-> (decode_packet.pc == next_pc ||
                      (redirect_pending && decode_packet.pc == redirect_target)))
    else begin
      value_errors++;
      $display("FAILED at %0t: o_decode_packet.pc = %h, expected %h", $time,
               $sampled(decode_packet.pc), $sampled(next_pc));
    end

  a_decode_credit_bound: assert property (@(posedge clock) disable iff (reset)
    decode_held <= `FETCH_DECODE_CREDITS)
    else begin
      value_errors++;
      $display("FAILED at %0t: decode_held = %0d, expected at most %0d", $time,
               $sampled(decode_held), `FETCH_DECODE_CREDITS);
    end

  a_reset_no_request: assert property (@(posedge clock)
    reset |=> (mem_req.command == BUS_NONE))
    else begin
      value_errors++;
      $display("FAILED at %0t: o_mem_req.command = %0d, expected %0d", $time,
               $sampled(mem_req.command), BUS_NONE);
    end

  a_reset_no_decode: assert property (@(posedge clock)
    reset |=> !decode_valid)
    else begin
      value_errors++;
      $display("FAILED at %0t: o_decode_valid = %b, expected 0", $time,
               $sampled(decode_valid));
    end

  a_tag_granted: assert property (@(posedge clock) disable iff (reset)
    (mem_resp.data_tag != '0) |-> granted[mem_resp.data_tag])
    else begin
      protocol_errors++;
      $display("data tag %0d came back at %0t without an outstanding grant.",
               $sampled(mem_resp.data_tag), $time);
    end

  // loads go out on whole 8 byte words.
  a_req_aligned: assert property (@(posedge clock) disable iff (reset)
    (mem_req.command == BUS_LOAD) |-> (mem_req.addr[`FETCH_OFFSET_BITS-1:0] == '0))
    else begin
      value_errors++;
      $display("FAILED at %0t: o_mem_req.addr = %h, expected %h", $time,
               $sampled(mem_req.addr), $sampled(mem_req.addr) & 16'hfff8);
    end

  // ########################################################################
  // stimulus
  // ########################################################################

  task automatic wait_for_packets(input int count, input int limit, input string what,
                                  output bit ok);
    int start;
    int cycles;
    start  = decoded_count;
    cycles = 0;
    ok     = 1'b1;
    while ((decoded_count - start < count) || redirect_pending) begin
      @(posedge clock);
      cycles++;
      if (cycles > limit) begin
        $display("timed out after %0d cycles waiting for %s.", limit, what);
        timeouts++;
        ok = 1'b0;
        break;
      end
    end
  endtask

  task automatic redirect_to(input logic [`FETCH_ADDR_BITS-1:0] target);
    @(posedge clock);
    #2;
    redirect    = 1'b1;
    redirect_pc = target;
    @(posedge clock);
    #2;
    redirect = 1'b0;
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d protocol, %0d timeout", value_errors,
             protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'hc791));
    reset       = 1'b1;
    redirect    = 1'b0;
    redirect_pc = '0;
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    wait_for_packets(64, 5000, "64 sequential packets from reset", run_ok);
    if (run_ok) begin
      redirect_to(16'hc3a8); // a cold region far from the first run.
      wait_for_packets(24, 5000, "packets after the first redirect", run_ok);
    end
    if (run_ok) begin
      redirect_to(16'h0148); // back into lines that may still be cached.
      wait_for_packets(24, 5000, "packets after the second redirect", run_ok);
    end
    finish_run();
  end

endmodule

// ==== sources.f ====
+incdir+common
common/mem_bus_pkg.sv
common/fetch_pkg.sv
icache/icache.sv
icache/miss_tracker.sv
logic/fetch_stage.sv
logic/inst_buffer.sv
logic/fetch_top.sv
verification/mem_model.sv
verification/fetch_tb.sv
